/* src/trace_pkg.sv */
// Instruction trace shared definitions

`default_nettype none

package trace_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int cycle_w    = 32;

  ////////////////////////////////////////////////////////////////////////////
  // rv32 major opcodes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_auipc  = 7'b0010111;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_fence  = 7'b0001111;
  localparam logic [6:0] opcode_system = 7'b1110011;

  // instruction format class
  typedef enum logic [3:0] {
    class_u,
    class_j,
    class_i,
    class_b,
    class_s,
    class_r,
    class_sys,
    class_fence,
    class_invalid
  } instr_class_e;

  ////////////////////////////////////////////////////////////////////////////
  // trace records
  ////////////////////////////////////////////////////////////////////////////

  // built in decode, 170 bits
  typedef struct packed {
    logic [cycle_w-1:0]    cycle;
    logic [xlen-1:0]       pc;
    logic [31:0]           instr;
    instr_class_e          iclass;
    logic [reg_addr_w-1:0] rd;
    logic                  rd_used;
    logic [xlen-1:0]       rs1_value;
    logic [xlen-1:0]       rs2_value;
  } id_record_t;

  // decode record plus execute results
  typedef struct packed {
    id_record_t      id;
    logic            rd_written;
    logic [xlen-1:0] rd_value;
    logic            mem_valid;
    logic            mem_we;
    logic [xlen-1:0] mem_addr;
  } ex_record_t;

  // same layout, as seen on the trace output
  typedef ex_record_t trace_record_t;

endpackage

`default_nettype wire

/* src/trace_ctrl.sv */
// Trace stage control

`timescale 1ns/1ps
`default_nettype none

module trace_ctrl import trace_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_enable,
  input  logic               id_valid,
  input  logic               is_decoding,
  input  logic               pipe_flush,
  input  logic               ex_valid,
  input  logic               wb_bypass,
  input  logic               wb_valid,
  input  logic               id_empty,
  input  logic               id_full,
  input  logic               wb_empty,
  input  logic               wb_full,
  output logic               id_push,
  output logic               ex_done,
  output logic               wb_push,
  output logic               wb_done,
  output logic [cycle_w-1:0] cycle,
  output logic               overflow
);

  logic enabled_q;
  logic decode_evt;
  logic id_drop;
  logic wb_drop;

  // decode or flush opens a new record
  assign decode_evt = enabled_q && ((id_valid && is_decoding) || pipe_flush);
  assign id_push    = decode_evt && !id_full;
  assign id_drop    = decode_evt && id_full;

  // execute ends on ex_valid, branches may skip writeback
  assign ex_done = !id_empty && (ex_valid || wb_bypass);
  assign wb_push = ex_done && !wb_full;
  assign wb_drop = ex_done && wb_full;

  assign wb_done = !wb_empty && wb_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enabled_q <= 1'b0;
      cycle     <= '0;
      overflow  <= 1'b0;
    end else begin
      if (fetch_enable)
        enabled_q <= 1'b1;
      cycle <= cycle + cycle_w'(1);
      // sticky until reset
      if (id_drop || wb_drop)
        overflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/instr_classifier.sv */
// Instruction classifier

`timescale 1ns/1ps
`default_nettype none

module instr_classifier import trace_pkg::*; (
  input  logic [cycle_w-1:0] cycle,
  input  logic [xlen-1:0]    pc,
  input  logic [31:0]        instr,
  input  logic [xlen-1:0]    rs1_value,
  input  logic [xlen-1:0]    rs2_value,
  output id_record_t         record
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [reg_addr_w-1:0] rd;
  instr_class_e          iclass;
  logic                  rs1_use;
  logic                  rs2_use;
  logic                  rd_cand;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];

  // major opcode to format class
  always_comb begin
    case (opcode)
      opcode_lui,
      opcode_auipc:  iclass = class_u;
      opcode_jal:    iclass = class_j;
      opcode_jalr,
      opcode_load,
      opcode_op_imm: iclass = class_i;
      opcode_branch: iclass = class_b;
      opcode_store:  iclass = class_s;
      opcode_op:     iclass = class_r;
      opcode_system: iclass = class_sys;
      opcode_fence:  iclass = class_fence;
      default:       iclass = class_invalid;
    endcase
  end

  // operand use per class
  assign rs1_use = (iclass == class_i) || (iclass == class_b) ||
                   (iclass == class_s) || (iclass == class_r);
  assign rs2_use = (iclass == class_b) || (iclass == class_s) || (iclass == class_r);

  // csr accesses write rd, ecall and friends do not
  assign rd_cand = (iclass == class_u) || (iclass == class_j) ||
                   (iclass == class_i) || (iclass == class_r) ||
                   ((iclass == class_sys) && (funct3 != 3'b000));

  always_comb begin
    record.cycle     = cycle;
    record.pc        = pc;
    record.instr     = instr;
    record.iclass    = iclass;
    record.rd        = rd;
    // x0 is never a real destination
    record.rd_used   = rd_cand && (rd != '0);
    record.rs1_value = rs1_use ? rs1_value : '0;
    record.rs2_value = rs2_use ? rs2_value : '0;
  end

endmodule

`default_nettype wire

/* src/trace_fifo.sv */
// Trace record queue

`timescale 1ns/1ps
`default_nettype none

module trace_fifo #(
  parameter type entry_t = logic [7:0],
  parameter int  depth   = 4
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   push,
  input  logic   pop,
  input  entry_t wdata,
  output entry_t rdata,
  output logic   empty,
  output logic   full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  entry_t             mem [depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;

  assign rdata = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));

  // record storage
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + ptr_w'(1);
      if (pop)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + ptr_w'(1);
      if (push && !pop)
        count <= count + cnt_w'(1);
      else if (pop && !push)
        count <= count - cnt_w'(1);
    end
  end

endmodule

`default_nettype wire

/* src/ex_capture.sv */
// Execute stage capture

`timescale 1ns/1ps
`default_nettype none

module ex_capture import trace_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  id_record_t            head,
  input  logic                  occupied,
  input  logic                  done,
  input  logic [reg_addr_w-1:0] reg_addr,
  input  logic                  reg_we,
  input  logic [xlen-1:0]       reg_wdata,
  input  logic                  data_req,
  input  logic                  data_gnt,
  input  logic                  data_we,
  input  logic [xlen-1:0]       data_addr,
  output ex_record_t            record
);

  logic            rd_written_q;
  logic [xlen-1:0] rd_value_q;
  logic            mem_valid_q;
  logic            mem_we_q;
  logic [xlen-1:0] mem_addr_q;
  logic            reg_hit;
  logic            mem_hit;

  // write to the head's destination this cycle
  assign reg_hit = occupied && reg_we && head.rd_used && (reg_addr == head.rd);
  // only the first granted access is kept
  assign mem_hit = occupied && data_req && data_gnt && !mem_valid_q;

  always_comb begin
    record.id         = head;
    record.rd_written = rd_written_q || reg_hit;
    record.rd_value   = reg_hit ? reg_wdata : (rd_written_q ? rd_value_q : '0);
    record.mem_valid  = mem_valid_q || mem_hit;
    record.mem_we     = mem_hit ? data_we : (mem_valid_q && mem_we_q);
    record.mem_addr   = mem_hit ? data_addr : (mem_valid_q ? mem_addr_q : '0);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_written_q <= 1'b0;
      mem_valid_q  <= 1'b0;
    end else if (done) begin
      rd_written_q <= 1'b0;
      mem_valid_q  <= 1'b0;
    end else begin
      if (reg_hit)
        rd_written_q <= 1'b1;
      if (mem_hit)
        mem_valid_q <= 1'b1;
    end
  end

  // payload registers behind the flags above
  always_ff @(posedge clk) begin
    if (reg_hit)
      rd_value_q <= reg_wdata;
    if (mem_hit) begin
      mem_we_q   <= data_we;
      mem_addr_q <= data_addr;
    end
  end

endmodule

`default_nettype wire

/* src/wb_capture.sv */
// Writeback stage capture and trace output

`timescale 1ns/1ps
`default_nettype none

module wb_capture import trace_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ex_record_t            head,
  input  logic                  occupied,
  input  logic                  done,
  input  logic [reg_addr_w-1:0] reg_addr,
  input  logic                  reg_we,
  input  logic [xlen-1:0]       reg_wdata,
  output logic                  trace_valid,
  output trace_record_t         trace
);

  logic            rd_written_q;
  logic [xlen-1:0] rd_value_q;
  logic            reg_hit;
  trace_record_t   merged;

  assign reg_hit = occupied && reg_we && head.id.rd_used && (reg_addr == head.id.rd);

  // writeback values take priority over execute ones
  always_comb begin
    merged            = head;
    merged.rd_written = head.rd_written || rd_written_q || reg_hit;
    if (reg_hit)
      merged.rd_value = reg_wdata;
    else if (rd_written_q)
      merged.rd_value = rd_value_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_written_q <= 1'b0;
      trace_valid  <= 1'b0;
    end else begin
      trace_valid <= done;
      if (done)
        rd_written_q <= 1'b0;
      else if (reg_hit)
        rd_written_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // payload registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reg_hit)
      rd_value_q <= reg_wdata;
    // output record held until the next one
    if (done)
      trace <= merged;
  end

endmodule

`default_nettype wire

/* src/trace_top.sv */
// Instruction trace unit top level

`timescale 1ns/1ps
`default_nettype none

module trace_top import trace_pkg::*; #(
  parameter int id_fifo_depth = 4,
  parameter int wb_fifo_depth = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_enable,
  input  logic [xlen-1:0]       pc,
  input  logic [31:0]           instr,
  input  logic                  id_valid,
  input  logic                  is_decoding,
  input  logic                  pipe_flush,
  input  logic [xlen-1:0]       rs1_value,
  input  logic [xlen-1:0]       rs2_value,
  input  logic                  ex_valid,
  input  logic [reg_addr_w-1:0] ex_reg_addr,
  input  logic                  ex_reg_we,
  input  logic [xlen-1:0]       ex_reg_wdata,
  input  logic                  ex_data_req,
  input  logic                  ex_data_gnt,
  input  logic                  ex_data_we,
  input  logic [xlen-1:0]       ex_data_addr,
  input  logic                  wb_bypass,
  input  logic                  wb_valid,
  input  logic [reg_addr_w-1:0] wb_reg_addr,
  input  logic                  wb_reg_we,
  input  logic [xlen-1:0]       wb_reg_wdata,
  output logic                  trace_valid,
  output trace_record_t         trace,
  output logic                  overflow
);

  logic               id_push;
  logic               ex_done;
  logic               wb_push;
  logic               wb_done;
  logic               id_empty;
  logic               id_full;
  logic               wb_empty;
  logic               wb_full;
  logic [cycle_w-1:0] cycle;
  id_record_t         id_rec;
  id_record_t         id_head;
  ex_record_t         ex_rec;
  ex_record_t         wb_head;

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////

  trace_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_enable (fetch_enable),
    .id_valid     (id_valid),
    .is_decoding  (is_decoding),
    .pipe_flush   (pipe_flush),
    .ex_valid     (ex_valid),
    .wb_bypass    (wb_bypass),
    .wb_valid     (wb_valid),
    .id_empty     (id_empty),
    .id_full      (id_full),
    .wb_empty     (wb_empty),
    .wb_full      (wb_full),
    .id_push      (id_push),
    .ex_done      (ex_done),
    .wb_push      (wb_push),
    .wb_done      (wb_done),
    .cycle        (cycle),
    .overflow     (overflow)
  );

  ////////////////////////////////////////////////////////////////////////////
  // decode, execute and writeback path
  ////////////////////////////////////////////////////////////////////////////

  instr_classifier u_classifier (
    .cycle     (cycle),
    .pc        (pc),
    .instr     (instr),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .record    (id_rec)
  );

  trace_fifo #(
    .entry_t (id_record_t),
    .depth   (id_fifo_depth)
  ) u_id_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (id_push),
    .pop   (ex_done),
    .wdata (id_rec),
    .rdata (id_head),
    .empty (id_empty),
    .full  (id_full)
  );

  ex_capture u_ex_capture (
    .clk       (clk),
    .rst_n     (rst_n),
    .head      (id_head),
    .occupied  (!id_empty),
    .done      (ex_done),
    .reg_addr  (ex_reg_addr),
    .reg_we    (ex_reg_we),
    .reg_wdata (ex_reg_wdata),
    .data_req  (ex_data_req),
    .data_gnt  (ex_data_gnt),
    .data_we   (ex_data_we),
    .data_addr (ex_data_addr),
    .record    (ex_rec)
  );

  // the ex record is dropped when this queue is full
  trace_fifo #(
    .entry_t (ex_record_t),
    .depth   (wb_fifo_depth)
  ) u_wb_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (wb_push),
    .pop   (wb_done),
    .wdata (ex_rec),
    .rdata (wb_head),
    .empty (wb_empty),
    .full  (wb_full)
  );

  wb_capture u_wb_capture (
    .clk         (clk),
    .rst_n       (rst_n),
    .head        (wb_head),
    .occupied    (!wb_empty),
    .done        (wb_done),
    .reg_addr    (wb_reg_addr),
    .reg_we      (wb_reg_we),
    .reg_wdata   (wb_reg_wdata),
    .trace_valid (trace_valid),
    .trace       (trace)
  );

endmodule

`default_nettype wire

/* tb/tb_trace_top.sv */
// Instruction trace unit testbench

`timescale 1ns/1ps
`default_nettype none

module tb_trace_top import trace_pkg::*; ();

  localparam int id_depth    = 4;
  localparam int wb_depth    = 4;
  localparam int max_wait    = 200;

  logic                  clk;
  logic                  rst_n;
  logic                  fetch_enable;
  logic [xlen-1:0]       pc;
  logic [31:0]           instr;
  logic                  id_valid;
  logic                  is_decoding;
  logic                  pipe_flush;
  logic [xlen-1:0]       rs1_value;
  logic [xlen-1:0]       rs2_value;
  logic                  ex_valid;
  logic [reg_addr_w-1:0] ex_reg_addr;
  logic                  ex_reg_we;
  logic [xlen-1:0]       ex_reg_wdata;
  logic                  ex_data_req;
  logic                  ex_data_gnt;
  logic                  ex_data_we;
  logic [xlen-1:0]       ex_data_addr;
  logic                  wb_bypass;
  logic                  wb_valid;
  logic [reg_addr_w-1:0] wb_reg_addr;
  logic                  wb_reg_we;
  logic [xlen-1:0]       wb_reg_wdata;
  logic                  trace_valid;
  trace_record_t         trace;
  logic                  overflow;

  // reference model state
  bit                    m_enabled;
  bit                    m_overflow;
  bit                    m_valid;
  logic [cycle_w-1:0]    m_cycle;
  id_record_t            id_q[$];
  ex_record_t            wb_q[$];
  trace_record_t         exp_out[$];
  bit                    ex_rdw;
  logic [xlen-1:0]       ex_rdv;
  bit                    ex_memv;
  bit                    ex_memwe;
  logic [xlen-1:0]       ex_memaddr;
  bit                    wb_rdw;
  logic [xlen-1:0]       wb_rdv;
  trace_record_t         exp_rec;
  int                    rec_count;

  trace_top #(
    .id_fifo_depth (id_depth),
    .wb_fifo_depth (wb_depth)
  ) dut (
    .clk          (clk),          .rst_n        (rst_n),
    .fetch_enable (fetch_enable), .pc           (pc),
    .instr        (instr),        .id_valid     (id_valid),
    .is_decoding  (is_decoding),  .pipe_flush   (pipe_flush),
    .rs1_value    (rs1_value),    .rs2_value    (rs2_value),
    .ex_valid     (ex_valid),     .ex_reg_addr  (ex_reg_addr),
    .ex_reg_we    (ex_reg_we),    .ex_reg_wdata (ex_reg_wdata),
    .ex_data_req  (ex_data_req),  .ex_data_gnt  (ex_data_gnt),
    .ex_data_we   (ex_data_we),   .ex_data_addr (ex_data_addr),
    .wb_bypass    (wb_bypass),    .wb_valid     (wb_valid),
    .wb_reg_addr  (wb_reg_addr),  .wb_reg_we    (wb_reg_we),
    .wb_reg_wdata (wb_reg_wdata), .trace_valid  (trace_valid),
    .trace        (trace),        .overflow     (overflow)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // error handling and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_record(input string name, input trace_record_t got,
                              input trace_record_t exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_class(input string name, input instr_class_e got,
                             input instr_class_e exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic instr_class_e decode_class(input logic [31:0] word);
    case (word[6:0])
      opcode_lui, opcode_auipc:              return class_u;
      opcode_jal:                            return class_j;
      opcode_jalr, opcode_load, opcode_op_imm: return class_i;
      opcode_branch:                         return class_b;
      opcode_store:                          return class_s;
      opcode_op:                             return class_r;
      opcode_system:                         return class_sys;
      opcode_fence:                          return class_fence;
      default:                               return class_invalid;
    endcase
  endfunction

  function automatic id_record_t build_id_record(input logic [cycle_w-1:0] stamp);
    id_record_t   rec;
    instr_class_e cls;
    bit           writes_rd;
    cls       = decode_class(instr);
    writes_rd = (cls inside {class_u, class_j, class_i, class_r}) ||
                ((cls == class_sys) && (instr[14:12] != 3'b000));
    rec.cycle     = stamp;
    rec.pc        = pc;
    rec.instr     = instr;
    rec.iclass    = cls;
    rec.rd        = instr[11:7];
    rec.rd_used   = writes_rd && (instr[11:7] != 5'd0);
    rec.rs1_value = (cls inside {class_i, class_b, class_s, class_r}) ? rs1_value : '0;
    rec.rs2_value = (cls inside {class_b, class_s, class_r}) ? rs2_value : '0;
    return rec;
  endfunction

  task automatic model_reset();
    m_enabled  = 1'b0;
    m_overflow = 1'b0;
    m_valid    = 1'b0;
    m_cycle    = '0;
    ex_rdw     = 1'b0;
    ex_rdv     = '0;
    ex_memv    = 1'b0;
    ex_memwe   = 1'b0;
    ex_memaddr = '0;
    wb_rdw     = 1'b0;
    wb_rdv     = '0;
    id_q.delete();
    wb_q.delete();
    exp_out.delete();
  endtask

  // model effect of the coming rising edge
  task automatic model_step();
    id_record_t    new_id;
    ex_record_t    new_ex;
    trace_record_t out_rec;
    bit            decode_evt;
    bit            id_full;
    bit            wb_full;
    bit            ex_done;
    bit            wb_done;
    new_id     = build_id_record(m_cycle);
    decode_evt = m_enabled && ((id_valid && is_decoding) || pipe_flush);
    id_full    = (id_q.size() == id_depth);
    wb_full    = (wb_q.size() == wb_depth);
    ex_done    = (id_q.size() != 0) && (ex_valid || wb_bypass);
    wb_done    = (wb_q.size() != 0) && wb_valid;
    // execute merge
    if (id_q.size() != 0) begin
      if (ex_reg_we && id_q[0].rd_used && (ex_reg_addr == id_q[0].rd)) begin
        ex_rdw = 1'b1;
        ex_rdv = ex_reg_wdata;
      end
      if (ex_data_req && ex_data_gnt && !ex_memv) begin
        ex_memv    = 1'b1;
        ex_memwe   = ex_data_we;
        ex_memaddr = ex_data_addr;
      end
    end
    // writeback merge
    if (wb_q.size() != 0) begin
      if (wb_reg_we && wb_q[0].id.rd_used && (wb_reg_addr == wb_q[0].id.rd)) begin
        wb_rdw = 1'b1;
        wb_rdv = wb_reg_wdata;
      end
    end
    if (wb_done) begin
      out_rec = wb_q.pop_front();
      if (wb_rdw) begin
        out_rec.rd_written = 1'b1;
        out_rec.rd_value   = wb_rdv;
      end
      exp_out.push_back(out_rec);
      wb_rdw = 1'b0;
    end
    if (ex_done) begin
      new_ex.id         = id_q.pop_front();
      new_ex.rd_written = ex_rdw;
      new_ex.rd_value   = ex_rdw ? ex_rdv : '0;
      new_ex.mem_valid  = ex_memv;
      new_ex.mem_we     = ex_memv && ex_memwe;
      new_ex.mem_addr   = ex_memv ? ex_memaddr : '0;
      if (!wb_full)
        wb_q.push_back(new_ex);
      ex_rdw  = 1'b0;
      ex_memv = 1'b0;
    end
    if (decode_evt && !id_full)
      id_q.push_back(new_id);
    if ((decode_evt && id_full) || (ex_done && wb_full))
      m_overflow = 1'b1;
    if (fetch_enable)
      m_enabled = 1'b1;
    m_valid = wb_done;
    m_cycle = m_cycle + 1;
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      model_reset();
    end else begin
      check_flag("trace_valid", trace_valid, m_valid);
      check_flag("overflow", overflow, m_overflow);
      if (trace_valid) begin
        if (exp_out.size() == 0) begin
          $display("trace record seen while the model expected none");
          stop_on_error();
        end
        exp_rec = exp_out.pop_front();
        rec_count++;
        check_class("trace.id.iclass", trace.id.iclass, exp_rec.id.iclass);
        check_record("trace", trace, exp_rec);
      end
      model_step();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic bit chance(input int pct);
    return ($urandom() % 100) < pct;
  endfunction

  function automatic logic [6:0] pick_opcode();
    case ($urandom() % 12)
      0:       return opcode_lui;
      1:       return opcode_auipc;
      2:       return opcode_jal;
      3:       return opcode_jalr;
      4:       return opcode_branch;
      5:       return opcode_load;
      6:       return opcode_store;
      7:       return opcode_op_imm;
      8:       return opcode_op;
      9:       return opcode_fence;
      10:      return opcode_system;
      default: return 7'($urandom());
    endcase
  endfunction

  task automatic drive_cycle(input int dec_pct, input int ex_pct, input int byp_pct,
                             input int wb_pct, input int flush_pct);
    @(posedge clk);
    #1;
    instr = $urandom();
    instr[6:0] = pick_opcode();
    if (chance(20))
      instr[11:7] = 5'd0;
    pc           = $urandom() & 32'hffff_fffc;
    id_valid     = chance(dec_pct);
    is_decoding  = chance(90);
    pipe_flush   = chance(flush_pct);
    rs1_value    = $urandom();
    rs2_value    = $urandom();
    ex_valid     = chance(ex_pct);
    wb_bypass    = chance(byp_pct);
    wb_valid     = chance(wb_pct);
    // aim register writes at the stage heads about half of the time
    ex_reg_addr  = (id_q.size() != 0 && chance(60)) ? id_q[0].rd : 5'($urandom());
    ex_reg_we    = chance(50);
    ex_reg_wdata = $urandom();
    ex_data_req  = chance(40);
    ex_data_gnt  = chance(50);
    ex_data_we   = chance(50);
    ex_data_addr = $urandom();
    wb_reg_addr  = (wb_q.size() != 0 && chance(60)) ? wb_q[0].id.rd : 5'($urandom());
    wb_reg_we    = chance(50);
    wb_reg_wdata = $urandom();
  endtask

  // run the stages until every record has left the unit
  task automatic drain();
    int waited;
    waited = 0;
    while (id_q.size() != 0 || wb_q.size() != 0 || exp_out.size() != 0 || m_valid) begin
      if (waited == max_wait) begin
        $display("timed out waiting for trace_valid while draining");
        stop_on_error();
      end
      drive_cycle(0, 100, 0, 100, 0);
      waited++;
    end
  endtask

  initial begin
    void'($urandom(46));
    clk          = 1'b0;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    pc           = '0;
    instr        = '0;
    id_valid     = 1'b0;
    is_decoding  = 1'b0;
    pipe_flush   = 1'b0;
    rs1_value    = '0;
    rs2_value    = '0;
    ex_valid     = 1'b0;
    ex_reg_addr  = '0;
    ex_reg_we    = 1'b0;
    ex_reg_wdata = '0;
    ex_data_req  = 1'b0;
    ex_data_gnt  = 1'b0;
    ex_data_we   = 1'b0;
    ex_data_addr = '0;
    wb_bypass    = 1'b0;
    wb_valid     = 1'b0;
    wb_reg_addr  = '0;
    wb_reg_we    = 1'b0;
    wb_reg_wdata = '0;
    rec_count    = 0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // decodes before fetch enable are not traced
    repeat (20) drive_cycle(60, 50, 20, 50, 10);

    // decode burst with execute stalled
    fetch_enable = 1'b1;
    repeat (12) drive_cycle(100, 0, 0, 100, 0);
    @(posedge clk);
    #1;
    check_flag("overflow after burst", overflow, 1'b1);
    drain();

    // random traffic with several records in flight
    repeat (1500) drive_cycle(30, 50, 15, 50, 5);
    drain();
    repeat (4) drive_cycle(0, 0, 0, 0, 0);

    if (exp_out.size() != 0 || rec_count == 0) begin
      $display("trace records missing at the end of the run");
      stop_on_error();
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* project.f */
src/trace_pkg.sv
src/trace_ctrl.sv
src/instr_classifier.sv
src/trace_fifo.sv
src/ex_capture.sv
src/wb_capture.sv
src/trace_top.sv
tb/tb_trace_top.sv
